// File: kcpu_pkg.sv
`default_nettype none

package kcpu_pkg;

    // register codes, same encoding as the tfr/exg postbyte nibbles
    typedef logic [3:0] reg_code_t;

    localparam reg_code_t REG_D  = 4'h0;
    localparam reg_code_t REG_X  = 4'h1;
    localparam reg_code_t REG_Y  = 4'h2;
    localparam reg_code_t REG_U  = 4'h3;
    localparam reg_code_t REG_S  = 4'h4;
    localparam reg_code_t REG_PC = 4'h5;
    localparam reg_code_t REG_A  = 4'h8;
    localparam reg_code_t REG_B  = 4'h9;
    localparam reg_code_t REG_CC = 4'ha;
    localparam reg_code_t REG_DP = 4'hb;

    typedef enum logic [2:0] {
        CMD_LOAD,
        CMD_PSH,
        CMD_PUL,
        CMD_TFR,
        CMD_EXG
    } cmd_kind_t;

    // psh/pul mask bits
    localparam logic [2:0] PSH_CC    = 3'd0;
    localparam logic [2:0] PSH_A     = 3'd1;
    localparam logic [2:0] PSH_B     = 3'd2;
    localparam logic [2:0] PSH_DP    = 3'd3;
    localparam logic [2:0] PSH_X     = 3'd4;
    localparam logic [2:0] PSH_Y     = 3'd5;
    localparam logic [2:0] PSH_OTHER = 3'd6; // u on the s stack, s on the u stack
    localparam logic [2:0] PSH_PC    = 3'd7;

    localparam int STACK_AW = 8; // low pointer bits used by the ram

    typedef struct packed {
        cmd_kind_t   kind;
        logic        use_u;
        logic [7:0]  mask;
        reg_code_t   dst;
        logic [15:0] value; // tfr/exg postbyte in the low byte
    } stack_cmd_t;

    typedef struct packed {
        logic [7:0]  a;
        logic [7:0]  b;
        logic [7:0]  dp;
        logic [7:0]  cc;
        logic [15:0] x;
        logic [15:0] y;
        logic [15:0] u;
        logic [15:0] s;
        logic [15:0] pc;
    } reg_view_t;

    typedef struct packed {
        logic        wr;
        logic        rd;
        logic [15:0] addr;
        logic [7:0]  wdata;
    } mem_req_t;

    // one step from the sequencer to the register file
    typedef struct packed {
        logic        load;
        logic        tfr;
        logic        exg;
        logic        psh_step;
        logic        pul_step;
        logic [7:0]  mask;  // bits still to move
        logic        hilon; // high byte of a 16-bit register
        logic        use_u;
        reg_code_t   dst;
        logic [15:0] value;
    } step_t;

    // highest set bit, push order
    function automatic logic [2:0] mask_top(input logic [7:0] m);
        logic [2:0] idx;
        idx = 3'd0;
        for (int i = 0; i < 8; i++) begin
            if (m[i]) idx = 3'(i);
        end
        return idx;
    endfunction

    // lowest set bit, pull order
    function automatic logic [2:0] mask_low(input logic [7:0] m);
        logic [2:0] idx;
        idx = 3'd0;
        for (int i = 7; i >= 0; i--) begin
            if (m[i]) idx = 3'(i);
        end
        return idx;
    endfunction

endpackage

`default_nettype wire

// File: kcpu_stack_ram.sv
`timescale 1ns/1ps
`default_nettype none

module kcpu_stack_ram
    import kcpu_pkg::*;
(
    input  wire           clk,
    input  wire mem_req_t mem,
    output logic [7:0]    rdata
);

    logic [7:0] ram [0:(1 << STACK_AW) - 1];

    // pointer wraps inside the low address bits
    always_ff @(posedge clk) begin
        if (mem.wr) ram[mem.addr[STACK_AW-1:0]] <= mem.wdata;
        if (mem.rd) rdata <= ram[mem.addr[STACK_AW-1:0]]; // one cycle read latency
    end

endmodule

`default_nettype wire

// File: kcpu_regs.sv
`timescale 1ns/1ps
`default_nettype none

module kcpu_regs
    import kcpu_pkg::*;
(
    input  wire            clk,
    input  wire            rst,
    input  wire step_t     step,
    input  wire [7:0]      rdata,
    output mem_req_t       mem,
    output reg_view_t      regs
);

    reg_view_t   nx;
    logic [15:0] sp;
    logic [15:0] sp_other;
    logic [15:0] nx_sp;
    logic [15:0] src_hi;   // register named by postbyte[7:4]
    logic [15:0] src_lo;   // register named by postbyte[3:0]
    logic [2:0]  psh_idx;
    logic [2:0]  pul_idx;
    logic [7:0]  psh_byte;
    logic        wb_vld;
    logic [2:0]  wb_idx;
    logic        wb_hi;
    logic        wb_use_u;

    // 8-bit registers read back with ff above them
    function automatic logic [15:0] rd16(input reg_view_t v, input reg_code_t c);
        case (c)
            REG_D:   rd16 = {v.a, v.b};
            REG_X:   rd16 = v.x;
            REG_Y:   rd16 = v.y;
            REG_U:   rd16 = v.u;
            REG_S:   rd16 = v.s;
            REG_PC:  rd16 = v.pc;
            REG_A:   rd16 = {8'hff, v.a};
            REG_B:   rd16 = {8'hff, v.b};
            REG_CC:  rd16 = {8'hff, v.cc};
            REG_DP:  rd16 = {8'hff, v.dp};
            default: rd16 = 16'h0000;
        endcase
    endfunction

    function automatic reg_view_t wr16(input reg_view_t v, input reg_code_t c,
                                       input logic [15:0] d);
        wr16 = v;
        case (c)
            REG_D: begin
                wr16.a = d[15:8];
                wr16.b = d[7:0];
            end
            REG_X:   wr16.x  = d;
            REG_Y:   wr16.y  = d;
            REG_U:   wr16.u  = d;
            REG_S:   wr16.s  = d;
            REG_PC:  wr16.pc = d;
            REG_A:   wr16.a  = d[7:0]; // low byte only
            REG_B:   wr16.b  = d[7:0];
            REG_CC:  wr16.cc = d[7:0];
            REG_DP:  wr16.dp = d[7:0];
            default: wr16 = v;         // unknown code, nothing written
        endcase
    endfunction

    function automatic logic [15:0] put_byte(input logic [15:0] r, input logic hi,
                                             input logic [7:0] d);
        return hi ? {d, r[7:0]} : {r[15:8], d};
    endfunction

    // push byte and stack address
    always_comb begin
        sp       = step.use_u ? regs.u : regs.s;
        sp_other = step.use_u ? regs.s : regs.u;
        psh_idx  = mask_top(step.mask);
        pul_idx  = mask_low(step.mask);
        case (psh_idx)
            PSH_CC:    psh_byte = regs.cc;
            PSH_A:     psh_byte = regs.a;
            PSH_B:     psh_byte = regs.b;
            PSH_DP:    psh_byte = regs.dp;
            PSH_X:     psh_byte = step.hilon ? regs.x[15:8] : regs.x[7:0];
            PSH_Y:     psh_byte = step.hilon ? regs.y[15:8] : regs.y[7:0];
            PSH_OTHER: psh_byte = step.hilon ? sp_other[15:8] : sp_other[7:0];
            default:   psh_byte = step.hilon ? regs.pc[15:8] : regs.pc[7:0];
        endcase
        nx_sp     = step.psh_step ? sp - 16'd1 : sp + 16'd1;
        mem.wr    = step.psh_step && (step.mask != 8'h00);
        mem.rd    = step.pul_step && (step.mask != 8'h00);
        mem.addr  = step.psh_step ? nx_sp : sp; // pre-decrement push, post-increment pull
        mem.wdata = psh_byte;
    end

    always_comb begin
        src_hi = rd16(regs, step.value[7:4]);
        src_lo = rd16(regs, step.value[3:0]);
        nx     = regs;
        if (step.load) nx = wr16(nx, step.dst, step.value);
        if (step.tfr || step.exg) nx = wr16(nx, step.value[3:0], src_hi);
        if (step.exg) nx = wr16(nx, step.value[7:4], src_lo); // second half of the swap
        if (mem.wr || mem.rd) begin
            if (step.use_u)
                nx.u = nx_sp;
            else
                nx.s = nx_sp;
        end
        // byte read last cycle lands in its register now
        if (wb_vld) begin
            case (wb_idx)
                PSH_CC: nx.cc = rdata;
                PSH_A:  nx.a  = rdata;
                PSH_B:  nx.b  = rdata;
                PSH_DP: nx.dp = rdata;
                PSH_X:  nx.x  = put_byte(nx.x, wb_hi, rdata);
                PSH_Y:  nx.y  = put_byte(nx.y, wb_hi, rdata);
                PSH_OTHER: begin
                    if (wb_use_u)
                        nx.s = put_byte(nx.s, wb_hi, rdata);
                    else
                        nx.u = put_byte(nx.u, wb_hi, rdata);
                end
                default: nx.pc = put_byte(nx.pc, wb_hi, rdata);
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            regs   <= '0;
            wb_vld <= 1'b0;
        end else begin
            regs   <= nx;
            wb_vld <= mem.rd;
        end
    end

    // which register the pending read belongs to
    always_ff @(posedge clk) begin
        wb_idx   <= pul_idx;
        wb_hi    <= step.hilon;
        wb_use_u <= step.use_u;
    end

endmodule

`default_nettype wire

// File: kcpu_stack_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module kcpu_stack_ctrl
    import kcpu_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire stack_cmd_t cmd,
    input  wire             cmd_valid,
    output step_t           step,
    output logic            busy,
    output logic            done
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ONE,   // load, tfr, exg
        ST_PSH,
        ST_PUL,
        ST_DRAIN  // last pull read still in flight
    } state_t;

    state_t     state;
    stack_cmd_t cmd_q;
    logic [7:0] rem_mask;
    logic       half;     // second byte of a 16-bit register
    logic [2:0] cur;
    logic [7:0] rem_clr;
    logic       last;

    always_comb begin
        cur          = (state == ST_PSH) ? mask_top(rem_mask) : mask_low(rem_mask);
        rem_clr      = rem_mask;
        rem_clr[cur] = 1'b0;
        // bits 4 and up are 16-bit registers
        last         = (rem_clr == 8'h00) && (!cur[2] || half);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ST_IDLE;
            rem_mask <= 8'h00;
            half     <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (cmd_valid) begin
                        rem_mask <= cmd.mask;
                        half     <= 1'b0;
                        case (cmd.kind)
                            CMD_PSH: state <= ST_PSH;
                            CMD_PUL: state <= ST_PUL;
                            default: state <= ST_ONE;
                        endcase
                    end
                end
                ST_ONE: begin
                    state <= ST_IDLE;
                    done  <= 1'b1;
                end
                ST_PSH, ST_PUL: begin
                    if (cur[2] && !half) begin
                        half <= 1'b1;
                    end else begin
                        half     <= 1'b0;
                        rem_mask <= rem_clr; // register finished
                    end
                    if (last) begin
                        if (state == ST_PSH || rem_mask == 8'h00) begin
                            state <= ST_IDLE; // empty pull has no read to drain
                            done  <= 1'b1;
                        end else begin
                            state <= ST_DRAIN;
                        end
                    end
                end
                ST_DRAIN: begin
                    state <= ST_IDLE;
                    done  <= 1'b1;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && cmd_valid) cmd_q <= cmd;
    end

    assign busy = (state != ST_IDLE);

    always_comb begin
        step.load     = (state == ST_ONE) && (cmd_q.kind == CMD_LOAD);
        step.tfr      = (state == ST_ONE) && (cmd_q.kind == CMD_TFR);
        step.exg      = (state == ST_ONE) && (cmd_q.kind == CMD_EXG);
        step.psh_step = (state == ST_PSH);
        step.pul_step = (state == ST_PUL);
        step.mask     = rem_mask;
        step.hilon    = (state == ST_PSH) ? half : !half; // push low first, pull high first
        step.use_u    = cmd_q.use_u;
        step.dst      = cmd_q.dst;
        step.value    = cmd_q.value;
    end

endmodule

`default_nettype wire

// File: kcpu_stack_top.sv
`timescale 1ns/1ps
`default_nettype none

module kcpu_stack_top
    import kcpu_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire stack_cmd_t cmd,
    input  wire             cmd_valid,
    output reg_view_t       regs,
    output logic            busy,
    output logic            done
);

    step_t      step;
    mem_req_t   mem;
    logic [7:0] rdata;  // stack byte, one cycle after the read

    kcpu_stack_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .step      (step),
        .busy      (busy),
        .done      (done)
    );

    kcpu_regs u_regs (
        .clk   (clk),
        .rst   (rst),
        .step  (step),
        .rdata (rdata),
        .mem   (mem),
        .regs  (regs)
    );

    kcpu_stack_ram u_ram (
        .clk   (clk),
        .mem   (mem),
        .rdata (rdata)
    );

endmodule

`default_nettype wire

// File: kcpu_stack_chk.sv
`timescale 1ns/1ps
`default_nettype none

module kcpu_stack_chk (
    input wire clk,
    input wire rst,
    input wire cmd_valid,
    input wire busy,
    input wire done
);

    // commands only go to an idle sequencer
    a_cmd_idle: assert property (@(posedge clk) disable iff (rst) cmd_valid |-> !busy)
        else $error("cmd_valid arrived while busy");

    a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done stayed high for more than one cycle");

    // sequencer leaves reset idle
    a_reset_idle: assert property (@(posedge clk) rst |=> !busy)
        else $error("busy high right after reset");

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period
    end

    // reset held over two rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: tb_kcpu_stack.sv
`timescale 1ns/1ps
`default_nettype none

module tb_kcpu_stack
    import kcpu_pkg::*;
();

    logic        clk;
    logic        rst;
    stack_cmd_t  cmd;
    logic        cmd_valid;
    reg_view_t   regs;
    logic        busy;
    logic        done;

    // stimulus table, filled before reset is released
    stack_cmd_t  tbl_cmd[$];
    reg_view_t   tbl_exp[$];
    int          tbl_busy[$];
    logic        table_ready = 1'b0;

    reg_view_t   mdl;              // reference register state
    logic [7:0]  mdl_mem [0:255];  // reference stack bytes
    logic [31:0] lfsr_q = 32'h576c_c205;

    int          rows_run = 0;
    int          rows_failed = 0;
    int          mismatches = 0;
    logic        row_bad;
    logic        stuck;

    tb_clk_gen i_clk (
        .clk (clk),
        .rst (rst)
    );

    kcpu_stack_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .regs      (regs),
        .busy      (busy),
        .done      (done)
    );

    bind kcpu_stack_ctrl kcpu_stack_chk i_chk (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .busy      (busy),
        .done      (done)
    );

    // galois lfsr, one step per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        r = 16'h0000;
        for (int i = 0; i < n; i++) begin
            r = {r[14:0], lfsr_q[0]};
            if (lfsr_q[0])
                lfsr_q = (lfsr_q >> 1) ^ 32'h8020_0003;
            else
                lfsr_q = lfsr_q >> 1;
        end
        return r;
    endfunction

    // 8-bit registers read as 16 bits carry ff on top
    function automatic logic [15:0] model_read(input reg_code_t c);
        case (c)
            REG_D:   return {mdl.a, mdl.b};
            REG_X:   return mdl.x;
            REG_Y:   return mdl.y;
            REG_U:   return mdl.u;
            REG_S:   return mdl.s;
            REG_PC:  return mdl.pc;
            REG_A:   return {8'hff, mdl.a};
            REG_B:   return {8'hff, mdl.b};
            REG_CC:  return {8'hff, mdl.cc};
            REG_DP:  return {8'hff, mdl.dp};
            default: return 16'h0000;
        endcase
    endfunction

    task automatic model_write(input reg_code_t c, input logic [15:0] d);
        case (c)
            REG_D: begin
                mdl.a = d[15:8];
                mdl.b = d[7:0];
            end
            REG_X:   mdl.x  = d;
            REG_Y:   mdl.y  = d;
            REG_U:   mdl.u  = d;
            REG_S:   mdl.s  = d;
            REG_PC:  mdl.pc = d;
            REG_A:   mdl.a  = d[7:0];
            REG_B:   mdl.b  = d[7:0];
            REG_CC:  mdl.cc = d[7:0];
            REG_DP:  mdl.dp = d[7:0];
            default: ; // invalid code
        endcase
    endtask

    // register behind a mask bit
    function automatic reg_code_t bit_code(input logic [2:0] idx, input logic use_u);
        case (idx)
            PSH_CC:    return REG_CC;
            PSH_A:     return REG_A;
            PSH_B:     return REG_B;
            PSH_DP:    return REG_DP;
            PSH_X:     return REG_X;
            PSH_Y:     return REG_Y;
            PSH_OTHER: return use_u ? REG_S : REG_U;
            default:   return REG_PC;
        endcase
    endfunction

    function automatic int byte_count(input logic [7:0] mask);
        int n;
        n = 0;
        for (int i = 0; i < 8; i++) begin
            if (mask[i]) n += (i >= 4) ? 2 : 1;
        end
        return n;
    endfunction

    // push from bit 7 down, pull from bit 0 up
    task automatic model_stack(input logic pull, input logic use_u, input logic [7:0] mask);
        logic [15:0] sp;
        logic [15:0] v;
        logic [2:0]  idx;
        sp = use_u ? mdl.u : mdl.s;
        for (int i = 0; i < 8; i++) begin
            idx = pull ? 3'(i) : 3'(7 - i);
            if (mask[idx]) begin
                v = model_read(bit_code(idx, use_u));
                if (!pull) begin
                    sp = sp - 16'd1;
                    mdl_mem[sp[7:0]] = v[7:0];
                    if (idx[2]) begin // high byte ends up below the low byte
                        sp = sp - 16'd1;
                        mdl_mem[sp[7:0]] = v[15:8];
                    end
                end else begin
                    if (idx[2]) begin
                        v[15:8] = mdl_mem[sp[7:0]];
                        sp = sp + 16'd1;
                    end
                    v[7:0] = mdl_mem[sp[7:0]];
                    sp = sp + 16'd1;
                    model_write(bit_code(idx, use_u), v);
                end
            end
        end
        if (use_u)
            mdl.u = sp;
        else
            mdl.s = sp;
    endtask

    task automatic add_row(input stack_cmd_t c);
        logic [15:0] src;
        logic [15:0] dst;
        int          n;
        n   = byte_count(c.mask);
        src = model_read(c.value[7:4]);
        dst = model_read(c.value[3:0]);
        case (c.kind)
            CMD_LOAD: model_write(c.dst, c.value);
            CMD_TFR:  model_write(c.value[3:0], src);
            CMD_EXG: begin
                model_write(c.value[3:0], src);
                model_write(c.value[7:4], dst);
            end
            CMD_PSH:  model_stack(1'b0, c.use_u, c.mask);
            default:  model_stack(1'b1, c.use_u, c.mask);
        endcase
        tbl_cmd.push_back(c);
        tbl_exp.push_back(mdl);
        if (c.kind == CMD_PUL)
            tbl_busy.push_back(n + 1); // extra cycle for the read latency
        else if (c.kind == CMD_PSH && n > 0)
            tbl_busy.push_back(n);
        else
            tbl_busy.push_back(1);
    endtask

    task automatic add_load(input reg_code_t code, input logic [15:0] value);
        stack_cmd_t c;
        c       = '0;
        c.kind  = CMD_LOAD;
        c.dst   = code;
        c.value = value;
        add_row(c);
    endtask

    task automatic add_xfer(input cmd_kind_t kind, input logic [7:0] postbyte);
        stack_cmd_t c;
        c       = '0;
        c.kind  = kind;
        c.value = {8'h00, postbyte};
        add_row(c);
    endtask

    task automatic add_stack(input cmd_kind_t kind, input logic use_u, input logic [7:0] mask);
        stack_cmd_t c;
        c       = '0;
        c.kind  = kind;
        c.use_u = use_u;
        c.mask  = mask;
        add_row(c);
    endtask

    // zero everything except the active stack pointer
    task automatic clear_regs(input logic use_u);
        add_load(REG_D, 16'h0000);
        add_load(REG_X, 16'h0000);
        add_load(REG_Y, 16'h0000);
        add_load(REG_PC, 16'h0000);
        add_load(REG_CC, 16'h0000);
        add_load(REG_DP, 16'h0000);
        add_load(use_u ? REG_S : REG_U, 16'h0000);
    endtask

    task automatic build_table();
        logic [15:0] r;
        logic [7:0]  m;
        mdl = '0;
        for (int i = 0; i < 16; i++) begin
            r = rand_bits(16);
            add_load(i[3:0], r); // codes 6, 7 and c..f write nothing
        end
        add_xfer(CMD_TFR, 8'h18); // x to a
        add_xfer(CMD_TFR, 8'h81); // a to x
        add_xfer(CMD_TFR, 8'ha2); // cc to y
        add_xfer(CMD_TFR, 8'h05); // d to pc
        add_xfer(CMD_TFR, 8'h61);
        add_xfer(CMD_TFR, 8'h1f);
        add_xfer(CMD_EXG, 8'h81);
        add_xfer(CMD_EXG, 8'h02);
        add_xfer(CMD_EXG, 8'h9b);
        // s and u areas kept apart in the ram
        add_load(REG_S, 16'h20c0);
        add_load(REG_U, 16'h3060);
        add_stack(CMD_PSH, 1'b0, 8'hff);
        clear_regs(1'b0);
        add_stack(CMD_PUL, 1'b0, 8'hff);
        add_stack(CMD_PSH, 1'b1, 8'hd3); // s goes through the u stack
        clear_regs(1'b1);
        add_stack(CMD_PUL, 1'b1, 8'hd3);
        add_load(REG_B, rand_bits(16));
        add_load(REG_Y, rand_bits(16));
        add_load(REG_DP, rand_bits(16));
        for (int i = 0; i < 6; i++) begin
            r = rand_bits(8);
            m = (r[7:0] == 8'h00) ? 8'h80 : r[7:0];
            r = rand_bits(1);
            add_stack(CMD_PSH, r[0], m);
            add_load(REG_X, rand_bits(16));
            add_load(REG_A, rand_bits(16));
            add_stack(CMD_PUL, r[0], m);
        end
        add_stack(CMD_PSH, 1'b0, 8'h00);
        add_stack(CMD_PSH, 1'b1, 8'h00);
        add_stack(CMD_PUL, 1'b0, 8'h00);
        add_stack(CMD_PUL, 1'b1, 8'h00);
    endtask

    task automatic check_value(input int r, input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("MISMATCH row %0d %s got %h exp %h", r, name, got, exp);
            mismatches++;
            row_bad = 1'b1;
        end
    endtask

    task automatic check_regs(input int r);
        reg_view_t e;
        e = tbl_exp[r];
        check_value(r, "regs.a", {8'h00, regs.a}, {8'h00, e.a});
        check_value(r, "regs.b", {8'h00, regs.b}, {8'h00, e.b});
        check_value(r, "regs.dp", {8'h00, regs.dp}, {8'h00, e.dp});
        check_value(r, "regs.cc", {8'h00, regs.cc}, {8'h00, e.cc});
        check_value(r, "regs.x", regs.x, e.x);
        check_value(r, "regs.y", regs.y, e.y);
        check_value(r, "regs.u", regs.u, e.u);
        check_value(r, "regs.s", regs.s, e.s);
        check_value(r, "regs.pc", regs.pc, e.pc);
    endtask

    task automatic run_row(input int r);
        stack_cmd_t c;
        cmd_kind_t  k;
        int         cycles;
        int         waited;
        logic       got_done;
        c        = tbl_cmd[r];
        k        = c.kind;
        cycles   = 0;
        waited   = 0;
        got_done = 1'b0;
        row_bad  = 1'b0;
        @(negedge clk);
        cmd       = c;
        cmd_valid = 1'b1;
        @(negedge clk);
        cmd_valid = 1'b0;
        while (!got_done && waited < 40) begin
            if (busy) cycles++;
            if (done) begin
                got_done = 1'b1;
            end else begin
                @(negedge clk);
                waited++;
            end
        end
        if (!got_done) begin
            $display("row %0d: done did not come within 40 cycles", r);
            row_bad = 1'b1;
            stuck   = 1'b1;
        end else begin
            check_value(r, "busy_cycles", 16'(cycles), 16'(tbl_busy[r]));
            check_regs(r);
        end
        rows_run++;
        if (row_bad) rows_failed++;
        $display("row %0d %s use_u %0d mask %h busy %0d %s", r, k.name(), c.use_u, c.mask,
                 cycles, row_bad ? "bad" : "ok");
    endtask

    initial begin
        cmd       = '0;
        cmd_valid = 1'b0;
        stuck     = 1'b0;
        build_table();
        table_ready = 1'b1;
        @(negedge rst);
        @(negedge clk);
        for (int r = 0; r < tbl_cmd.size() && !stuck; r++) begin
            run_row(r);
        end
        $display("rows run %0d, rows failed %0d, mismatches %0d",
                 rows_run, rows_failed, mismatches);
        if (rows_failed == 0 && rows_run == tbl_cmd.size()) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // 40 cycles per row at most
    initial begin
        wait (table_ready);
        repeat (tbl_cmd.size() * 40) @(posedge clk);
        $display("watchdog expired before the last row finished");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
kcpu_pkg.sv
kcpu_stack_ram.sv
kcpu_regs.sv
kcpu_stack_ctrl.sv
kcpu_stack_top.sv
kcpu_stack_chk.sv
tb_clk_gen.sv
tb_kcpu_stack.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_kcpu_stack -f files.f -o sim_kcpu

out=$(./obj_dir/sim_kcpu)
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
